/* hw/net_params.svh */
`ifndef NET_PARAMS_SVH
`define NET_PARAMS_SVH

// --------------------------------------------------
// timing, all counted in tx_clock cycles or seconds
// --------------------------------------------------
`define NET_TICKS_PER_SEC      20      // cycles per second, kept short for sim
`define NET_SETTLE_SECS        1       // link settle before address acquisition
`define NET_DHCP_GIVEUP_SECS   15      // no offer by then -> link-local
`define NET_RETRY_GAP_TICKS    4       // cycles of quiet before a retransmit
`define NET_DEFAULT_LEASE_SECS 43200   // renew interval for a zero lease
`define NET_RENEW_ACK_SECS     20      // wait for ack after a renew request
`define NET_RENEW_RETRY_SECS   300     // back-off after a failed renewal
`define NET_SEC_W              18      // seconds counter width

// --------------------------------------------------
// ports and addresses
// --------------------------------------------------
`define NET_DHCP_CLIENT_PORT   16'd68
`define NET_DATA_PORT          16'd1024
`define NET_LINKLOCAL_PREFIX   16'hA9FE  // 169.254

`endif

/* hw/net_pkg.sv */
`default_nettype none

package net_pkg;

  // --------------------------------------------------
  // frame sources, lowest value wins arbitration
  // --------------------------------------------------
  typedef enum logic [1:0] {
    PROTO_ARP  = 2'd0,
    PROTO_ICMP = 2'd1,
    PROTO_DHCP = 2'd2,
    PROTO_UDP  = 2'd3
  } tx_proto_e;

  // address manager states
  typedef enum logic [3:0] {
    ST_LINK_WAIT  = 4'd0,  // no link
    ST_SETTLE     = 4'd1,  // link up, letting it settle
    ST_DHCP_REQ   = 4'd2,  // fire a discover
    ST_DHCP_WAIT  = 4'd3,  // count seconds, wait for offer
    ST_DHCP_RETRY = 4'd4,  // short gap before retransmit
    ST_RUNNING    = 4'd5,  // static or link-local address
    ST_RENEW_WAIT = 4'd6,  // leased, counting down to renewal
    ST_RENEW_REQ  = 4'd7,
    ST_RENEW_ACK  = 4'd8
  } lease_state_e;

  // one remote end of a frame
  typedef struct packed {
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
  } endpoint_t;

  // header handed to the sender
  typedef struct packed {
    endpoint_t   dest;
    logic [15:0] local_port;
    logic [15:0] length;
  } route_t;

  // request lines, field order follows priority
  typedef struct packed {
    logic arp;
    logic icmp;
    logic dhcp;
    logic udp;
  } tx_reqs_t;

endpackage

`default_nettype wire

/* hw/ip_lease_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

`include "net_params.svh"

module ip_lease_fsm (
  input  wire logic        tx_clock,
  input  wire logic        rst_n,
  input  wire logic        link_up,
  input  wire logic [31:0] static_ip,
  input  wire logic [47:0] local_mac,
  input  wire logic        dhcp_success,
  input  wire logic [31:0] dhcp_ip_accept,
  input  wire logic [31:0] dhcp_lease,
  output logic      [31:0] local_ip,
  output logic             network_state,   // high while no address
  output logic             dhcp_tx_request, // one-cycle pulse
  output logic             dhcp_rx_enable,
  output logic      [3:0]  dhcp_seconds     // secs field for the DHCP engine
);

  localparam int unsigned TICKS  = `NET_TICKS_PER_SEC;
  localparam int unsigned TICK_W = $clog2(TICKS + 1);
  localparam int unsigned GAP    = `NET_RETRY_GAP_TICKS;
  localparam int unsigned GAP_W  = $clog2(GAP + 1);

  net_pkg::lease_state_e     state;
  logic [TICK_W-1:0]         tick_cnt;     // seconds prescaler
  logic                      tick;         // one cycle per second
  logic [`NET_SEC_W-1:0]     sec_cnt;      // settle / renew countdown
  logic [GAP_W-1:0]          gap_cnt;      // retransmit gap, in cycles
  logic                      static_valid;
  logic [31:0]               linklocal_ip;
  logic [`NET_SEC_W-1:0]     renew_secs;

  // half the lease, saturated into the seconds counter
  function automatic logic [`NET_SEC_W-1:0] half_lease(input logic [31:0] lease);
    logic [31:0] half;
    half = lease >> 1;
    if (lease == 32'd0)
      return `NET_SEC_W'(`NET_DEFAULT_LEASE_SECS);
    else if (half > {{(32-`NET_SEC_W){1'b0}}, {`NET_SEC_W{1'b1}}})
      return {`NET_SEC_W{1'b1}};   // very long lease, clip
    else
      return half[`NET_SEC_W-1:0];
  endfunction

  assign tick         = (tick_cnt == TICK_W'(TICKS - 1));
  assign static_valid = (static_ip != 32'd0) && (static_ip != 32'hFFFF_FFFF);
  assign linklocal_ip = {`NET_LINKLOCAL_PREFIX, local_mac[15:0]};
  assign renew_secs   = half_lease(dhcp_lease);

  // --------------------------------------------------
  // acquisition and renewal
  // --------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      state           <= net_pkg::ST_LINK_WAIT;
      tick_cnt        <= '0;
      sec_cnt         <= '0;
      gap_cnt         <= '0;
      local_ip        <= '0;
      network_state   <= 1'b1;
      dhcp_tx_request <= 1'b0;
      dhcp_rx_enable  <= 1'b0;
      dhcp_seconds    <= '0;
    end else begin
      dhcp_tx_request <= 1'b0;                       // pulse only
      tick_cnt        <= tick ? '0 : tick_cnt + 1'b1; // free run, states may restart it

      if (state != net_pkg::ST_LINK_WAIT && !link_up) begin
        // link gone, drop the address and start over
        state          <= net_pkg::ST_LINK_WAIT;
        network_state  <= 1'b1;
        dhcp_rx_enable <= 1'b0;
      end else begin
        case (state)
          net_pkg::ST_LINK_WAIT: begin
            network_state <= 1'b1;
            if (link_up) begin
              sec_cnt  <= `NET_SEC_W'(`NET_SETTLE_SECS);
              tick_cnt <= '0;                        // settle starts on a whole second
              state    <= net_pkg::ST_SETTLE;
            end
          end

          net_pkg::ST_SETTLE: begin
            if (sec_cnt == '0) begin
              if (static_valid) begin
                local_ip      <= static_ip;
                network_state <= 1'b0;
                state         <= net_pkg::ST_RUNNING;
              end else begin
                local_ip     <= '0;                  // 0.0.0.0 while asking
                dhcp_seconds <= '0;
                tick_cnt     <= '0;
                state        <= net_pkg::ST_DHCP_REQ;
              end
            end else if (tick) begin
              sec_cnt <= sec_cnt - 1'b1;
            end
          end

          net_pkg::ST_DHCP_REQ: begin
            dhcp_tx_request <= 1'b1;
            dhcp_rx_enable  <= 1'b1;
            state           <= net_pkg::ST_DHCP_WAIT;
          end

          net_pkg::ST_DHCP_WAIT: begin
            if (dhcp_success) begin
              local_ip       <= dhcp_ip_accept;
              network_state  <= 1'b0;
              dhcp_rx_enable <= 1'b0;
              sec_cnt        <= renew_secs;
              tick_cnt       <= '0;
              state          <= net_pkg::ST_RENEW_WAIT;
            end else if (tick) begin
              dhcp_seconds <= dhcp_seconds + 1'b1;   // old value tested below
              if (dhcp_seconds == 4'd0 || dhcp_seconds == 4'd2 || dhcp_seconds == 4'd6) begin
                gap_cnt <= GAP_W'(GAP);
                state   <= net_pkg::ST_DHCP_RETRY;   // discover again at 1, 3, 7 s
              end else if (dhcp_seconds == 4'(`NET_DHCP_GIVEUP_SECS - 1)) begin
                local_ip       <= linklocal_ip;     // give up, self-assign
                network_state  <= 1'b0;
                dhcp_rx_enable <= 1'b0;
                state          <= net_pkg::ST_RUNNING;
              end
            end
          end

          net_pkg::ST_DHCP_RETRY: begin
            dhcp_rx_enable <= 1'b0;
            if (gap_cnt == '0)
              state <= net_pkg::ST_DHCP_REQ;
            else
              gap_cnt <= gap_cnt - 1'b1;
          end

          net_pkg::ST_RUNNING: begin
            network_state  <= 1'b0;
            dhcp_rx_enable <= 1'b0;
          end

          // address stays usable through the renewal states
          net_pkg::ST_RENEW_WAIT: begin
            dhcp_rx_enable <= 1'b0;
            if (sec_cnt == '0)
              state <= net_pkg::ST_RENEW_REQ;
            else if (tick)
              sec_cnt <= sec_cnt - 1'b1;
          end

          net_pkg::ST_RENEW_REQ: begin
            dhcp_tx_request <= 1'b1;
            dhcp_rx_enable  <= 1'b1;
            sec_cnt         <= `NET_SEC_W'(`NET_RENEW_ACK_SECS);
            tick_cnt        <= '0;
            state           <= net_pkg::ST_RENEW_ACK;
          end

          net_pkg::ST_RENEW_ACK: begin
            if (dhcp_success) begin
              dhcp_rx_enable <= 1'b0;
              sec_cnt        <= renew_secs;
              tick_cnt       <= '0;
              state          <= net_pkg::ST_RENEW_WAIT;
            end else if (sec_cnt == '0) begin
              dhcp_rx_enable <= 1'b0;
              sec_cnt        <= `NET_SEC_W'(`NET_RENEW_RETRY_SECS);  // no ack, back off
              tick_cnt       <= '0;
              state          <= net_pkg::ST_RENEW_WAIT;
            end else if (tick) begin
              sec_cnt <= sec_cnt - 1'b1;
            end
          end

          default: state <= net_pkg::ST_LINK_WAIT;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hw/tx_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_arbiter (
  input  wire logic             tx_clock,
  input  wire logic             rst_n,
  input  wire net_pkg::tx_reqs_t reqs,
  input  wire logic             sender_busy,
  output net_pkg::tx_proto_e    proto,
  output logic                  tx_ready,
  output logic                  tx_start
);

  net_pkg::tx_proto_e pick;
  logic               pick_valid;

  // fixed priority, arp first
  always_comb begin
    pick_valid = 1'b1;
    if (reqs.arp)
      pick = net_pkg::PROTO_ARP;
    else if (reqs.icmp)
      pick = net_pkg::PROTO_ICMP;
    else if (reqs.dhcp)
      pick = net_pkg::PROTO_DHCP;
    else begin
      pick       = net_pkg::PROTO_UDP;
      pick_valid = reqs.udp;   // nothing asked
    end
  end

  // --------------------------------------------------
  // ready -> start -> wait for busy
  // --------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n) begin
      proto    <= net_pkg::PROTO_ARP;
      tx_ready <= 1'b0;
      tx_start <= 1'b0;
    end else if (tx_start && sender_busy) begin
      tx_ready <= 1'b0;        // sender has it, back to idle
      tx_start <= 1'b0;
    end else if (tx_ready) begin
      tx_start <= 1'b1;        // held until busy
    end else if (pick_valid) begin
      proto    <= pick;        // only sampled while idle
      tx_ready <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* hw/tx_route_select.sv */
`timescale 1ns/1ns
`default_nettype none

`include "net_params.svh"

module tx_route_select (
  input  wire logic               tx_clock,
  input  wire logic               rst_n,
  input  wire logic               run,
  input  wire net_pkg::tx_proto_e proto,
  input  wire logic               tx_start,
  input  wire net_pkg::endpoint_t arp_dest,
  input  wire net_pkg::endpoint_t icmp_dest,
  input  wire net_pkg::endpoint_t dhcp_dest,
  input  wire net_pkg::endpoint_t udp_dest,
  input  wire logic [15:0]        icmp_length,
  input  wire logic [15:0]        dhcp_length,
  input  wire logic [15:0]        udp_length,
  output net_pkg::route_t         route,
  output logic                    udp_tx_enable,
  output logic                    arp_tx_enable,
  output logic                    icmp_tx_enable
);

  localparam logic [15:0] ARP_LENGTH = 16'd28;  // fixed arp payload

  net_pkg::endpoint_t udp_held;   // udp peer frozen while running

  // --------------------------------------------------
  // udp destination, tracks input until run rises
  // --------------------------------------------------
  always_ff @(posedge tx_clock or negedge rst_n) begin
    if (!rst_n)
      udp_held <= '0;
    else if (!run)
      udp_held <= udp_dest;
  end

  // header for the granted source
  always_comb begin
    route.local_port = `NET_DATA_PORT;
    case (proto)
      net_pkg::PROTO_ARP: begin
        route.dest   = arp_dest;
        route.length = ARP_LENGTH;
      end
      net_pkg::PROTO_ICMP: begin
        route.dest   = icmp_dest;
        route.length = icmp_length;
      end
      net_pkg::PROTO_DHCP: begin
        route.dest       = dhcp_dest;
        route.length     = dhcp_length;
        route.local_port = `NET_DHCP_CLIENT_PORT;   // client side of bootp
      end
      default: begin
        route.dest   = udp_held;
        route.length = udp_length;
      end
    endcase
  end

  // source enables, dhcp rides on the udp sender
  assign udp_tx_enable  = tx_start && (proto == net_pkg::PROTO_UDP ||
                                       proto == net_pkg::PROTO_DHCP);
  assign arp_tx_enable  = tx_start && (proto == net_pkg::PROTO_ARP);
  assign icmp_tx_enable = tx_start && (proto == net_pkg::PROTO_ICMP);

endmodule

`default_nettype wire

/* hw/net_tx_core.sv */
`timescale 1ns/1ns
`default_nettype none

module net_tx_core (
  input  wire logic               tx_clock,
  input  wire logic               rst_n,
  // address manager
  input  wire logic               link_up,
  input  wire logic [31:0]        static_ip,
  input  wire logic [47:0]        local_mac,
  input  wire logic               dhcp_success,
  input  wire logic [31:0]        dhcp_ip_accept,
  input  wire logic [31:0]        dhcp_lease,
  output logic      [31:0]        local_ip,
  output logic                    network_state,
  output logic                    dhcp_tx_request,
  output logic                    dhcp_rx_enable,
  output logic      [3:0]         dhcp_seconds,
  // frame sources
  input  wire logic               arp_tx_request,
  input  wire logic               icmp_tx_request,
  input  wire logic               udp_tx_request,
  input  wire logic               sender_busy,
  input  wire logic               run,
  input  wire net_pkg::endpoint_t arp_dest,
  input  wire net_pkg::endpoint_t icmp_dest,
  input  wire net_pkg::endpoint_t dhcp_dest,
  input  wire net_pkg::endpoint_t udp_dest,
  input  wire logic [15:0]        icmp_length,
  input  wire logic [15:0]        dhcp_length,
  input  wire logic [15:0]        udp_length,
  // to the sender
  output net_pkg::tx_proto_e      proto,
  output logic                    tx_ready,
  output logic                    tx_start,
  output net_pkg::route_t         route,
  output logic                    udp_tx_enable,
  output logic                    arp_tx_enable,
  output logic                    icmp_tx_enable
);

  net_pkg::tx_reqs_t reqs;

  // field order arp, icmp, dhcp, udp
  assign reqs = {arp_tx_request, icmp_tx_request, dhcp_tx_request, udp_tx_request};

  // --------------------------------------------------
  // address acquisition
  // --------------------------------------------------
  ip_lease_fsm u_lease (
    .tx_clock        (tx_clock),
    .rst_n           (rst_n),
    .link_up         (link_up),
    .static_ip       (static_ip),
    .local_mac       (local_mac),
    .dhcp_success    (dhcp_success),
    .dhcp_ip_accept  (dhcp_ip_accept),
    .dhcp_lease      (dhcp_lease),
    .local_ip        (local_ip),
    .network_state   (network_state),
    .dhcp_tx_request (dhcp_tx_request),
    .dhcp_rx_enable  (dhcp_rx_enable),
    .dhcp_seconds    (dhcp_seconds)
  );

  // --------------------------------------------------
  // transmit dispatch
  // --------------------------------------------------
  tx_arbiter u_arb (
    .tx_clock    (tx_clock),
    .rst_n       (rst_n),
    .reqs        (reqs),
    .sender_busy (sender_busy),
    .proto       (proto),
    .tx_ready    (tx_ready),
    .tx_start    (tx_start)
  );

  tx_route_select u_route (
    .tx_clock       (tx_clock),
    .rst_n          (rst_n),
    .run            (run),
    .proto          (proto),
    .tx_start       (tx_start),
    .arp_dest       (arp_dest),
    .icmp_dest      (icmp_dest),
    .dhcp_dest      (dhcp_dest),
    .udp_dest       (udp_dest),
    .icmp_length    (icmp_length),
    .dhcp_length    (dhcp_length),
    .udp_length     (udp_length),
    .route          (route),
    .udp_tx_enable  (udp_tx_enable),
    .arp_tx_enable  (arp_tx_enable),
    .icmp_tx_enable (icmp_tx_enable)
  );

endmodule

`default_nettype wire

/* verification/tb_net_tx_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "net_params.svh"

module tb_net_tx_core;

  localparam int T                = `NET_TICKS_PER_SEC;  // cycles per second
  localparam int ARB_ROUNDS       = 20;
  localparam int ZERO_WINDOW_SECS = 10;                  // quiet time after a zero lease
  // rough budget in seconds, per phase
  localparam int TEST_SECS   = 2 * ARB_ROUNDS + 3 + 9 + (ZERO_WINDOW_SECS + 2) + 17;
  localparam int WATCHDOG_NS = (TEST_SECS + TEST_SECS / 2) * T * 4;

  logic tx_clock = 1'b0;
  logic rst_n;
  logic link_up;
  logic [31:0] static_ip;
  logic [47:0] local_mac;
  logic dhcp_success;
  logic [31:0] dhcp_ip_accept;
  logic [31:0] dhcp_lease;
  logic [31:0] local_ip;
  logic network_state;
  logic dhcp_tx_request;
  logic dhcp_rx_enable;
  logic [3:0] dhcp_seconds;
  logic arp_tx_request;
  logic icmp_tx_request;
  logic udp_tx_request;
  logic sender_busy;
  logic run;
  net_pkg::endpoint_t arp_dest;
  net_pkg::endpoint_t icmp_dest;
  net_pkg::endpoint_t dhcp_dest;
  net_pkg::endpoint_t udp_dest;
  logic [15:0] icmp_length;
  logic [15:0] dhcp_length;
  logic [15:0] udp_length;
  net_pkg::tx_proto_e proto;
  logic tx_ready;
  logic tx_start;
  net_pkg::route_t route;
  logic udp_tx_enable;
  logic arp_tx_enable;
  logic icmp_tx_enable;

  // reference side
  logic [31:0]        rng = 32'h3c988f92;
  logic [1:0]         busy_delay = 2'd0;   // sender reaction, in cycles
  net_pkg::endpoint_t udp_at_run;         // udp peer when run went high
  logic [31:0]        exp_ip;             // address expected once network_state is low
  logic               static_mode;        // no discover allowed
  logic               no_req_window;      // no renewal allowed
  logic               any_req;
  net_pkg::tx_proto_e pick_ref;
  logic [2:0]         enables;

  net_tx_core DUT (.*);

  always #2 tx_clock = ~tx_clock;

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic net_pkg::endpoint_t rand_endpoint();
    net_pkg::endpoint_t e;
    logic [31:0] a;
    logic [31:0] b;
    a = next_rand();
    b = next_rand();
    e.mac  = {a[15:0], b};
    e.ip   = next_rand();
    e.port = a[31:16];
    return e;
  endfunction

  // arp beats icmp beats dhcp beats udp
  function automatic net_pkg::tx_proto_e top_priority(input logic a, input logic i,
                                                       input logic d, input logic u);
    if (a)
      return net_pkg::PROTO_ARP;
    else if (i)
      return net_pkg::PROTO_ICMP;
    else if (d)
      return net_pkg::PROTO_DHCP;
    return net_pkg::PROTO_UDP;
  endfunction

  // {arp, icmp, udp}, dhcp frames leave through the udp sender
  function automatic logic [2:0] enables_ref(input logic start, input net_pkg::tx_proto_e p);
    if (!start)
      return 3'b000;
    case (p)
      net_pkg::PROTO_ARP:  return 3'b100;
      net_pkg::PROTO_ICMP: return 3'b010;
      default:             return 3'b001;
    endcase
  endfunction

  function automatic net_pkg::route_t route_ref(input net_pkg::tx_proto_e p);
    net_pkg::route_t r;
    r.local_port = `NET_DATA_PORT;
    case (p)
      net_pkg::PROTO_ARP: begin
        r.dest   = arp_dest;
        r.length = 16'd28;
      end
      net_pkg::PROTO_ICMP: begin
        r.dest   = icmp_dest;
        r.length = icmp_length;
      end
      net_pkg::PROTO_DHCP: begin
        r.dest       = dhcp_dest;
        r.length     = dhcp_length;
        r.local_port = 16'd68;      // bootp client
      end
      default: begin
        r.dest   = run ? udp_at_run : udp_dest;
        r.length = udp_length;
      end
    endcase
    return r;
  endfunction

  task automatic end_in_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic flag_mismatch(input string what);
    end_in_failure($sformatf("[ERROR] %0t ns: %s", $time, what));
  endtask

  // next edge, then 1 ns for driving and reading
  task automatic step();
    @(posedge tx_clock);
    #1;
  endtask

  task automatic cycles_until_address(output int n);
    n = 0;
    while (network_state) begin
      step();
      n++;
    end
  endtask

  task automatic cycles_until_dhcp_request(output int n);
    n = 0;
    while (!dhcp_tx_request) begin
      step();
      n++;
    end
  endtask

  task automatic drop_link();
    link_up = 1'b0;
    step();
    assert (network_state) else flag_mismatch("network_state low after link loss");
    step();
  endtask

  // one random set of frame requests, each held until its enable shows
  task automatic arbitration_round();
    logic [31:0] r;
    r = next_rand();
    busy_delay  = r[5:4];
    arp_dest    = rand_endpoint();
    icmp_dest   = rand_endpoint();
    dhcp_dest   = rand_endpoint();
    icmp_length = r[31:16];
    udp_length  = r[15:0] ^ r[31:16];
    run         = 1'b0;
    udp_dest    = rand_endpoint();
    step();
    if (r[6]) begin
      run        = 1'b1;              // freeze the udp peer
      udp_at_run = udp_dest;
      step();
      udp_dest   = rand_endpoint();   // must not reach the route
    end
    arp_tx_request  = r[0];
    icmp_tx_request = r[1];
    udp_tx_request  = r[2] | (r[2:0] == 3'b000);
    while (arp_tx_request || icmp_tx_request || udp_tx_request || tx_ready) begin
      step();
      if (arp_tx_enable)
        arp_tx_request = 1'b0;
      if (icmp_tx_enable)
        icmp_tx_request = 1'b0;
      if (udp_tx_enable)
        udp_tx_request = 1'b0;
    end
  endtask

  // --------------------------------------------------
  // concurrent checks
  // --------------------------------------------------
  assign any_req  = arp_tx_request | icmp_tx_request | udp_tx_request | dhcp_tx_request;
  assign pick_ref = top_priority(arp_tx_request, icmp_tx_request, dhcp_tx_request,
                                 udp_tx_request);
  assign enables  = {arp_tx_enable, icmp_tx_enable, udp_tx_enable};

  req_to_start: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (any_req && !tx_ready) |-> ##2 tx_start)
    else flag_mismatch("tx_start not 2 cycles after request");

  grant_order: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (any_req && !tx_ready) |=> (proto == $past(pick_ref)))
    else flag_mismatch("proto is not the highest-priority request");

  start_holds: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (tx_start && !sender_busy) |=> tx_start)
    else flag_mismatch("tx_start dropped before sender_busy");

  busy_clears: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (tx_start && sender_busy) |=> (!tx_start && !tx_ready))
    else flag_mismatch("handshake not cleared 1 cycle after sender_busy");

  source_enables: assert property (@(posedge tx_clock) disable iff (!rst_n)
    enables == enables_ref(tx_start, proto))
    else flag_mismatch($sformatf("enables %b wrong for proto %0d", enables, proto));

  route_header: assert property (@(posedge tx_clock) disable iff (!rst_n)
    tx_start |-> (route == route_ref(proto)))
    else flag_mismatch("route header does not match granted source");

  udp_frozen: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (run && proto == net_pkg::PROTO_UDP) |-> (route.dest == udp_at_run))
    else flag_mismatch("udp route moved while run is high");

  link_loss: assert property (@(posedge tx_clock) disable iff (!rst_n)
    !link_up |=> network_state)
    else flag_mismatch("network_state not high after link loss");

  address_value: assert property (@(posedge tx_clock) disable iff (!rst_n)
    !network_state |-> (local_ip == exp_ip))
    else flag_mismatch($sformatf("local_ip %h, expected %h", local_ip, exp_ip));

  static_quiet: assert property (@(posedge tx_clock) disable iff (!rst_n)
    (static_mode || no_req_window) |-> !dhcp_tx_request)
    else flag_mismatch("unexpected dhcp_tx_request");

  // sender side, answers each start with a one-cycle busy
  initial begin : sender_model
    sender_busy = 1'b0;
    forever begin
      step();
      if (tx_start) begin
        repeat (busy_delay) step();
        sender_busy = 1'b1;
        step();
        sender_busy = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    end_in_failure("timeout: the tests did not finish in the expected time");
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    int n;
    int half;
    int req_at[$];
    int secs_at[$];                  // secs field seen on each retransmit
    int retry_secs[3] = '{1, 3, 7};
    rst_n           = 1'b0;
    link_up         = 1'b0;
    static_ip       = '0;
    local_mac       = '0;
    dhcp_success    = 1'b0;
    dhcp_ip_accept  = '0;
    dhcp_lease      = '0;
    arp_tx_request  = 1'b0;
    icmp_tx_request = 1'b0;
    udp_tx_request  = 1'b0;
    run             = 1'b0;
    arp_dest        = '0;
    icmp_dest       = '0;
    dhcp_dest       = '0;
    udp_dest        = '0;
    udp_at_run      = '0;
    icmp_length     = '0;
    dhcp_length     = 16'd300;
    udp_length      = '0;
    exp_ip          = '0;
    static_mode     = 1'b0;
    no_req_window   = 1'b0;
    repeat (5) @(posedge tx_clock);
    #1 rst_n = 1'b1;
    step();
    assert (network_state && !tx_ready && !tx_start && !dhcp_tx_request &&
            !dhcp_rx_enable && local_ip == 32'd0 && enables == 3'b000)
      else flag_mismatch("outputs not idle after reset");
    r = next_rand();
    local_mac = {16'h0200, r};

    repeat (ARB_ROUNDS) arbitration_round();
    run = 1'b0;

    // static address, no discover
    r = next_rand();
    static_ip   = {8'd10, r[23:0]};
    exp_ip      = {8'd10, r[23:0]};
    static_mode = 1'b1;
    link_up     = 1'b1;
    cycles_until_address(n);
    assert (n >= `NET_SETTLE_SECS * T && n <= (`NET_SETTLE_SECS + 1) * T)
      else flag_mismatch($sformatf("static address after %0d cycles", n));
    drop_link();
    static_ip   = '0;
    static_mode = 1'b0;

    // lease, then renewal at half of it
    r = next_rand();
    dhcp_ip_accept = {8'd192, 8'd168, r[15:0]};
    dhcp_lease     = 32'd4 + {29'd0, r[18:16]};
    half           = int'(dhcp_lease >> 1);
    exp_ip         = dhcp_ip_accept;
    link_up        = 1'b1;
    cycles_until_dhcp_request(n);
    dhcp_success = 1'b1;
    step();
    dhcp_success = 1'b0;
    cycles_until_dhcp_request(n);
    assert (!network_state && local_ip == exp_ip) else flag_mismatch("leased address lost");
    assert (n >= (half - 2) * T && n <= (half + 2) * T)
      else flag_mismatch($sformatf("renewal after %0d cycles, lease %0d s", n, dhcp_lease));
    drop_link();

    // zero lease uses the long default interval
    dhcp_ip_accept = {8'd192, 8'd168, r[31:16]};
    dhcp_lease     = '0;
    exp_ip         = dhcp_ip_accept;
    link_up        = 1'b1;
    cycles_until_dhcp_request(n);
    dhcp_success = 1'b1;
    step();
    dhcp_success  = 1'b0;
    no_req_window = 1'b1;
    repeat (ZERO_WINDOW_SECS * T) step();
    no_req_window = 1'b0;
    assert (!network_state) else flag_mismatch("no address after zero lease");
    drop_link();

    // silent server, retransmits then link-local
    exp_ip  = {8'd169, 8'd254, local_mac[15:0]};
    link_up = 1'b1;
    cycles_until_dhcp_request(n);
    assert (dhcp_seconds == 4'd0)
      else flag_mismatch($sformatf("dhcp_seconds %0d on first discover", dhcp_seconds));
    n = 0;
    while (network_state) begin
      step();
      n++;
      if (dhcp_tx_request) begin
        req_at.push_back(n);
        secs_at.push_back(dhcp_seconds);
      end
    end
    assert (req_at.size() == 3)
      else flag_mismatch($sformatf("%0d discovers, expected 4", req_at.size() + 1));
    for (int k = 0; k < 3; k++) begin
      assert (req_at[k] >= (retry_secs[k] - 1) * T && req_at[k] <= (retry_secs[k] + 1) * T)
        else flag_mismatch($sformatf("retransmit %0d at cycle %0d", k + 1, req_at[k]));
      assert (secs_at[k] == retry_secs[k])
        else flag_mismatch($sformatf("dhcp_seconds %0d on retransmit %0d, expected %0d",
                                     secs_at[k], k + 1, retry_secs[k]));
    end
    assert (n >= (`NET_DHCP_GIVEUP_SECS - 1) * T && n <= (`NET_DHCP_GIVEUP_SECS + 1) * T)
      else flag_mismatch($sformatf("link-local address after %0d cycles", n));
    step();

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/net_pkg.sv
hw/ip_lease_fsm.sv
hw/tx_arbiter.sv
hw/tx_route_select.sv
hw/net_tx_core.sv
verification/tb_net_tx_core.sv

/* Makefile */
# Verilator build and run of the transmit core testbench

VERILATOR ?= verilator
TOP       ?= tb_net_tx_core
FLAGS     ?= --binary --timing --assert -j 0
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# pass only when the run prints the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f compile.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
